// ==== verilog/rename_macros.svh ====
// rename front end sizing
// dispatch width, register file sizes and instruction buffer depth

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// pipe width
//////////////////////////////////////////////////////////////////////

// instructions accepted, dispatched and renamed per cycle
`define N 3

//////////////////////////////////////////////////////////////////////
// register files
//////////////////////////////////////////////////////////////////////

// architectural registers, index 0 means no register
`define ARCH_REG_SZ 32

// physical registers, the upper half starts out free
`define PHYS_REG_SZ 64

//////////////////////////////////////////////////////////////////////
// buffering
//////////////////////////////////////////////////////////////////////

// instruction buffer entries, power of two so pointers wrap on overflow
`define IB_SZ 8

`endif

// ==== verilog/rename_pkg.sv ====
// rename package
// register index, count, opcode and packet types shared by the rename front end

`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    //////////////////////////////////////////////////////////////////////
    // indices and counts
    //////////////////////////////////////////////////////////////////////

    // architectural index, 0 reads as no register
    typedef logic [$clog2(`ARCH_REG_SZ)-1:0] arch_reg_idx;

    // physical index
    typedef logic [$clog2(`PHYS_REG_SZ)-1:0] phys_reg_idx;

    // buffer-sized count, also used for outside space
    typedef logic [$clog2(`IB_SZ+1)-1:0] count_t;

    // 0..N instructions per cycle
    typedef logic [$clog2(`N+1)-1:0] dis_count_t;

    // free list occupancy
    typedef logic [$clog2(`PHYS_REG_SZ+1)-1:0] fl_count_t;

    //////////////////////////////////////////////////////////////////////
    // instruction class
    //////////////////////////////////////////////////////////////////////

    // not interpreted here, only carried through rename
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_mult   = 3'd1,
        op_load   = 3'd2,
        op_store  = 3'd3,
        op_branch = 3'd4
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////////////////////////

    // decoded instruction from the producer
    typedef struct packed {
        logic        valid;
        opcode_e     opcode;
        arch_reg_idx reg1;
        arch_reg_idx reg2;
        arch_reg_idx dest_reg_idx;
    } inst_packet;

    // physical sources, new dest and the mapping it replaced
    typedef struct packed {
        logic        valid;
        opcode_e     opcode;
        phys_reg_idx t1;
        phys_reg_idx t2;
        phys_reg_idx t;
        phys_reg_idx t_old;
    } renamed_packet;

    // allocation view of the free list and retired registers coming back
    typedef struct packed {
        logic        valid;
        phys_reg_idx reg_idx;
    } free_reg_packet;

endpackage

`default_nettype wire

// ==== verilog/inst_buffer.sv ====
// instruction buffer
// circular queue between decode and rename, up to N writes and N reads per cycle

`timescale 1ns/10ps
`default_nettype none

`include "rename_macros.svh"

module inst_buffer (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire rename_pkg::inst_packet [`N-1:0] in_insts,
    input  wire rename_pkg::count_t              num_accept,
    input  wire rename_pkg::dis_count_t          num_dispatch,
    output rename_pkg::inst_packet      [`N-1:0] ib_insts,
    output rename_pkg::count_t                   buffered_count,
    output rename_pkg::count_t                   open_entries
);

    localparam int PTR_W = $clog2(`IB_SZ);

    // queue storage
    rename_pkg::inst_packet mem [`IB_SZ];

    // pointers and occupancy
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    rename_pkg::count_t count;

    // per-slot addresses for this cycle
    logic [PTR_W-1:0] wr_ptr [`N];
    logic [PTR_W-1:0] rd_ptr [`N];

    // slot i sits i entries past the pointer, wraps by truncation
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            wr_ptr[i] = tail + PTR_W'(i);
            rd_ptr[i] = head + PTR_W'(i);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    // producer keeps num_accept within open_entries
    always_ff @(posedge clock) begin
        for (int i = 0; i < `N; i++) begin
            if (i < num_accept) begin
                mem[wr_ptr[i]] <= in_insts[i];
            end
        end
    end

    // pointer and count update, read and write in the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(num_dispatch);
            tail  <= tail + PTR_W'(num_accept);
            count <= count + num_accept - rename_pkg::count_t'(num_dispatch);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    // head window, anything past occupancy shows invalid
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            ib_insts[i]       = mem[rd_ptr[i]];
            ib_insts[i].valid = mem[rd_ptr[i]].valid && (i < count);
        end
    end

    assign buffered_count = count;

    // advertised to the producer
    assign open_entries = rename_pkg::count_t'(`IB_SZ) - count;

endmodule

`default_nettype wire

// ==== verilog/dispatch_ctrl.sv ====
// dispatch control
// picks how many buffered instructions leave for rename this cycle

`timescale 1ns/10ps
`default_nettype none

`include "rename_macros.svh"

module dispatch_ctrl (
    input  wire rename_pkg::count_t    buffered_count,
    input  wire rename_pkg::count_t    rob_open,
    input  wire rename_pkg::count_t    rs_open,
    input  wire rename_pkg::fl_count_t free_count,
    output rename_pkg::dis_count_t     num_dispatch
);

    // running minimum, starts at the pipe width
    rename_pkg::count_t lim;

    always_comb begin
        lim = rename_pkg::count_t'(`N);

        // what is buffered
        if (buffered_count < lim) begin
            lim = buffered_count;
        end

        // room downstream
        if (rob_open < lim) begin
            lim = rob_open;
        end
        if (rs_open < lim) begin
            lim = rs_open;
        end

        // whole-group stall when a full group could not be given dests
        if (free_count < rename_pkg::fl_count_t'(`N)) begin
            num_dispatch = '0;
        end else begin
            num_dispatch = rename_pkg::dis_count_t'(lim);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/free_list.sv ====
// free list
// FIFO of free physical registers, multi-pop on dispatch and multi-push on retire

`timescale 1ns/10ps
`default_nettype none

`include "rename_macros.svh"

module free_list (
    input  wire                                      clock,
    input  wire                                      reset,
    input  wire rename_pkg::inst_packet     [`N-1:0] dispatch_insts,
    input  wire rename_pkg::dis_count_t              num_dispatch,
    input  wire rename_pkg::free_reg_packet [`N-1:0] retire_regs,
    output rename_pkg::free_reg_packet      [`N-1:0] fl_regs,
    output rename_pkg::fl_count_t                    free_count
);

    localparam int PTR_W = $clog2(`PHYS_REG_SZ);

    rename_pkg::phys_reg_idx mem [`PHYS_REG_SZ];

    logic [PTR_W-1:0]      head;
    logic [PTR_W-1:0]      tail;
    rename_pkg::fl_count_t count;

    rename_pkg::dis_count_t num_pop;
    rename_pkg::dis_count_t num_push;

    // where each retire slot lands
    logic [PTR_W-1:0] push_ptr [`N];

    //////////////////////////////////////////////////////////////////////
    // pop and push counts
    //////////////////////////////////////////////////////////////////////

    // one pop per dispatched instruction with a real dest
    always_comb begin
        num_pop = '0;
        for (int i = 0; i < `N; i++) begin
            if ((i < num_dispatch) && dispatch_insts[i].valid &&
                (dispatch_insts[i].dest_reg_idx != '0)) begin
                num_pop = num_pop + 1'b1;
            end
        end
    end

    // valid retire entries pack in index order, gaps skipped
    always_comb begin
        num_push = '0;
        for (int i = 0; i < `N; i++) begin
            push_ptr[i] = tail + PTR_W'(num_push);
            if (retire_regs[i].valid) begin
                num_push = num_push + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////////////////////////

    // after reset the list is the upper physical registers in order
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REG_SZ - `ARCH_REG_SZ; i++) begin
                mem[i] <= rename_pkg::phys_reg_idx'(`ARCH_REG_SZ + i);
            end
        end else begin
            for (int i = 0; i < `N; i++) begin
                if (retire_regs[i].valid) begin
                    mem[push_ptr[i]] <= retire_regs[i].reg_idx;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= PTR_W'(`PHYS_REG_SZ - `ARCH_REG_SZ);
            count <= rename_pkg::fl_count_t'(`PHYS_REG_SZ - `ARCH_REG_SZ);
        end else begin
            head  <= head + PTR_W'(num_pop);
            tail  <= tail + PTR_W'(num_push);
            count <= count - rename_pkg::fl_count_t'(num_pop)
                           + rename_pkg::fl_count_t'(num_push);
        end
    end

    // head window in pop order
    always_comb begin
        for (int k = 0; k < `N; k++) begin
            fl_regs[k].reg_idx = mem[head + PTR_W'(k)];
            fl_regs[k].valid   = (k < count);
        end
    end

    assign free_count = count;

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
// map table
// renames sources and dests of a dispatch group, bypassing earlier group writes

`timescale 1ns/10ps
`default_nettype none

`include "rename_macros.svh"

module map_table (
    input  wire                                      clock,
    input  wire                                      reset,
    input  wire rename_pkg::inst_packet     [`N-1:0] dispatch_insts,
    input  wire rename_pkg::dis_count_t              num_dispatch,
    input  wire rename_pkg::free_reg_packet [`N-1:0] fl_regs,
    output rename_pkg::renamed_packet       [`N-1:0] renamed_insts
);

    // arch index to current physical register
    rename_pkg::phys_reg_idx map [`ARCH_REG_SZ];

    // combinational rename result, registered at the edge
    rename_pkg::renamed_packet [`N-1:0] next_renamed;

    // slot dispatches and takes a new register
    logic [`N-1:0] has_dest;

    //////////////////////////////////////////////////////////////////////
    // lookup and intra-group bypass
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // allocating instructions seen so far in the group
        int n_alloc;
        n_alloc = 0;
        for (int i = 0; i < `N; i++) begin
            next_renamed[i].valid  = dispatch_insts[i].valid && (i < num_dispatch);
            next_renamed[i].opcode = dispatch_insts[i].opcode;
            has_dest[i] = next_renamed[i].valid && (dispatch_insts[i].dest_reg_idx != '0);

            // table lookup, map[0] stays 0 since it is never written
            next_renamed[i].t1    = map[dispatch_insts[i].reg1];
            next_renamed[i].t2    = map[dispatch_insts[i].reg2];
            next_renamed[i].t_old = map[dispatch_insts[i].dest_reg_idx];
            next_renamed[i].t     = '0;

            // earlier writers in the group win, the latest one last
            for (int j = 0; j < i; j++) begin
                if (has_dest[j]) begin
                    if (dispatch_insts[j].dest_reg_idx == dispatch_insts[i].reg1) begin
                        next_renamed[i].t1 = next_renamed[j].t;
                    end
                    if (dispatch_insts[j].dest_reg_idx == dispatch_insts[i].reg2) begin
                        next_renamed[i].t2 = next_renamed[j].t;
                    end
                    if (dispatch_insts[j].dest_reg_idx == dispatch_insts[i].dest_reg_idx) begin
                        next_renamed[i].t_old = next_renamed[j].t;
                    end
                end
            end

            // k-th allocator takes the k-th free list head entry
            if (has_dest[i]) begin
                next_renamed[i].t = fl_regs[n_alloc].reg_idx;
                n_alloc++;
            end else begin
                next_renamed[i].t_old = '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////////////////////////

    // identity after reset, writes in slot order so the last writer sticks
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REG_SZ; a++) begin
                map[a] <= rename_pkg::phys_reg_idx'(a);
            end
        end else begin
            for (int i = 0; i < `N; i++) begin
                if (has_dest[i]) begin
                    map[dispatch_insts[i].dest_reg_idx] <= next_renamed[i].t;
                end
            end
        end
    end

    // renamed group leaves one edge after dispatch
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `N; i++) begin
                renamed_insts[i].valid <= 1'b0;
            end
        end else begin
            renamed_insts <= next_renamed;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_core.sv ====
// rename core
// instruction buffer, dispatch control, free list and map table of the rename stage

`timescale 1ns/10ps
`default_nettype none

`include "rename_macros.svh"

module rename_core (
    input  wire                                      clock,
    input  wire                                      reset,
    input  wire rename_pkg::inst_packet     [`N-1:0] in_insts,
    input  wire rename_pkg::count_t                  num_input,
    input  wire rename_pkg::count_t                  rob_open,
    input  wire rename_pkg::count_t                  rs_open,
    input  wire rename_pkg::free_reg_packet [`N-1:0] retire_regs,
    output rename_pkg::count_t                       ib_open,
    output rename_pkg::renamed_packet       [`N-1:0] renamed_insts
);

    //////////////////////////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////////////////////////

    // buffer head window and fill level
    rename_pkg::inst_packet [`N-1:0] ib_insts;
    rename_pkg::count_t              buffered_count;

    // instructions leaving the buffer this cycle
    rename_pkg::dis_count_t num_dispatch;

    // free list head window and fill level
    rename_pkg::free_reg_packet [`N-1:0] fl_regs;
    rename_pkg::fl_count_t               free_count;

    //////////////////////////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////////////////////////

    inst_buffer u_inst_buffer (
        .clock          (clock),
        .reset          (reset),
        .in_insts       (in_insts),
        .num_accept     (num_input),
        .num_dispatch   (num_dispatch),
        .ib_insts       (ib_insts),
        .buffered_count (buffered_count),
        .open_entries   (ib_open)
    );

    // stall policy
    dispatch_ctrl u_dispatch_ctrl (
        .buffered_count (buffered_count),
        .rob_open       (rob_open),
        .rs_open        (rs_open),
        .free_count     (free_count),
        .num_dispatch   (num_dispatch)
    );

    free_list u_free_list (
        .clock          (clock),
        .reset          (reset),
        .dispatch_insts (ib_insts),
        .num_dispatch   (num_dispatch),
        .retire_regs    (retire_regs),
        .fl_regs        (fl_regs),
        .free_count     (free_count)
    );

    map_table u_map_table (
        .clock          (clock),
        .reset          (reset),
        .dispatch_insts (ib_insts),
        .num_dispatch   (num_dispatch),
        .fl_regs        (fl_regs),
        .renamed_insts  (renamed_insts)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset source
// free running clock, synchronous reset held for a fixed number of cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2.0) clock = ~clock;
    end

    // reset drops just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/rename_core_tb.sv ====
// rename core testbench
// directed and random groups checked against a sequential rename model

`timescale 1ns/10ps
`default_nettype none

`include "rename_macros.svh"

module rename_core_tb;

    //////////////////////////////////////////////////////////////////////
    // run length
    //////////////////////////////////////////////////////////////////////

    // groups staged by the directed tests, then by the random run
    localparam int DIRECTED_GROUPS = 25;
    localparam int RAND_GROUPS     = 150;
    localparam int TEST_GROUPS     = DIRECTED_GROUPS + RAND_GROUPS;
    localparam int CYCLE_LIMIT     = 40 * TEST_GROUPS + 200;

    logic clock;
    logic reset;

    // DUT ports
    rename_pkg::inst_packet     [`N-1:0] in_insts;
    rename_pkg::count_t                  num_input;
    rename_pkg::count_t                  rob_open;
    rename_pkg::count_t                  rs_open;
    rename_pkg::free_reg_packet [`N-1:0] retire_regs;
    rename_pkg::count_t                  ib_open;
    rename_pkg::renamed_packet  [`N-1:0] renamed_insts;

    integer seed;

    // reference model state
    rename_pkg::phys_reg_idx model_map [`ARCH_REG_SZ];
    rename_pkg::phys_reg_idx model_fl[$];
    rename_pkg::phys_reg_idx pending_free[$];
    rename_pkg::inst_packet  stage_q[$];
    rename_pkg::inst_packet  exp_q[$];

    int err_count;
    int fail_count;
    int out_count;
    int acc_count;
    int cycles;

    // dispatch limits in force one cycle before the outputs appear
    int last_push;
    int last_space;

    // stimulus knobs, a negative space knob means random
    int rob_knob;
    int rs_knob;
    bit retire_on;
    bit stall_expect;

    tb_clock_gen #(.PERIOD(8.0), .RESET_CYCLES(16)) u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    rename_core DUT (
        .clock         (clock),
        .reset         (reset),
        .in_insts      (in_insts),
        .num_input     (num_input),
        .rob_open      (rob_open),
        .rs_open       (rs_open),
        .retire_regs   (retire_regs),
        .ib_open       (ib_open),
        .renamed_insts (renamed_insts)
    );

    //////////////////////////////////////////////////////////////////////
    // instruction makers and reference rename
    //////////////////////////////////////////////////////////////////////

    function automatic rename_pkg::inst_packet make_inst(input int r1, input int r2,
                                                         input int d);
        rename_pkg::inst_packet p;
        p.valid        = 1'b1;
        p.opcode       = rename_pkg::op_alu;
        p.reg1         = rename_pkg::arch_reg_idx'(r1);
        p.reg2         = rename_pkg::arch_reg_idx'(r2);
        p.dest_reg_idx = rename_pkg::arch_reg_idx'(d);
        return p;
    endfunction

    // small register range so groups collide often
    function automatic rename_pkg::inst_packet random_inst(input bit need_dest);
        rename_pkg::inst_packet p;
        p.valid        = 1'b1;
        p.opcode       = rename_pkg::opcode_e'($unsigned($random(seed)) % 5);
        p.reg1         = rename_pkg::arch_reg_idx'($unsigned($random(seed)) % 12);
        p.reg2         = rename_pkg::arch_reg_idx'($unsigned($random(seed)) % 12);
        p.dest_reg_idx = rename_pkg::arch_reg_idx'($unsigned($random(seed)) % 8);
        if (need_dest) begin
            p.dest_reg_idx = rename_pkg::arch_reg_idx'(1 + $unsigned($random(seed)) % 31);
        end
        return p;
    endfunction

    // one instruction at a time, so earlier group members are already in the map
    function automatic rename_pkg::renamed_packet ref_rename(input rename_pkg::inst_packet inst);
        rename_pkg::renamed_packet r;
        r.valid  = 1'b1;
        r.opcode = inst.opcode;
        r.t1     = model_map[inst.reg1];
        r.t2     = model_map[inst.reg2];
        r.t      = '0;
        r.t_old  = '0;
        // arch 0 never renamed, no dest means no allocation
        if (inst.dest_reg_idx != '0) begin
            r.t     = model_fl.pop_front();
            r.t_old = model_map[inst.dest_reg_idx];
            model_map[inst.dest_reg_idx] = r.t;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    // fields in order op t1 t2 t t_old
    task automatic compare_renamed(input int slot, input rename_pkg::renamed_packet got,
                                   input rename_pkg::renamed_packet exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t renamed_insts[%0d] got %0d %0d %0d %0d %0d exp %0d %0d %0d %0d %0d",
                     $time, slot, got.opcode, got.t1, got.t2, got.t, got.t_old,
                     exp.opcode, exp.t1, exp.t2, exp.t, exp.t_old);
        end
    endtask

    task automatic compare_count(input string name, input rename_pkg::count_t got,
                                 input rename_pkg::count_t exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // one cycle of drive, inputs change 1 ns after the edge
    task automatic step();
        int n;
        @(posedge clock);
        #1;
        n = stage_q.size();
        if (n > `N) n = `N;
        if (n > ib_open) n = ib_open;
        in_insts = '0;
        for (int i = 0; i < n; i++) begin
            in_insts[i] = stage_q.pop_front();
            exp_q.push_back(in_insts[i]);
            acc_count++;
        end
        num_input = rename_pkg::count_t'(n);
        rob_open  = (rob_knob < 0) ?
                    rename_pkg::count_t'($unsigned($random(seed)) % (`IB_SZ + 1)) :
                    rename_pkg::count_t'(rob_knob);
        rs_open   = (rs_knob < 0) ?
                    rename_pkg::count_t'($unsigned($random(seed)) % (`IB_SZ + 1)) :
                    rename_pkg::count_t'(rs_knob);
        // oldest freed registers first, random slots so gaps appear
        retire_regs = '0;
        for (int i = 0; i < `N; i++) begin
            if (retire_on && (pending_free.size() != 0) && ($random(seed) & 1)) begin
                retire_regs[i].valid   = 1'b1;
                retire_regs[i].reg_idx = pending_free.pop_front();
            end
        end
    endtask

    // until every staged instruction came out and was retired
    task automatic drain();
        while ((stage_q.size() != 0) || (exp_q.size() != 0) ||
               (retire_on && (pending_free.size() != 0))) begin
            step();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // output checking, mid cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        rename_pkg::renamed_packet exp_pkt;
        bit seen_gap;
        int n_valid;
        int avail;
        seen_gap = 1'b0;
        if (!reset) begin
            // free list size the DUT saw when this group dispatched
            n_valid = 0;
            avail   = model_fl.size() - last_push;
            for (int i = 0; i < `N; i++) begin
                if (renamed_insts[i].valid) begin
                    n_valid++;
                end
                if (!renamed_insts[i].valid) begin
                    seen_gap = 1'b1;
                end else if (seen_gap) begin
                    fail_count++;
                    $display("slot %0d valid after an invalid slot at %0t", i, $time);
                end else if (stall_expect) begin
                    fail_count++;
                    $display("renamed output in slot %0d while dispatch is blocked at %0t",
                             i, $time);
                end else if (exp_q.size() == 0) begin
                    fail_count++;
                    $display("renamed output at %0t with no accepted instruction left", $time);
                end else if ((exp_q[0].dest_reg_idx != '0) && (model_fl.size() == 0)) begin
                    fail_count++;
                    $display("register allocated at %0t with the free list empty", $time);
                end else begin
                    exp_pkt = ref_rename(exp_q.pop_front());
                    compare_renamed(i, renamed_insts[i], exp_pkt);
                    out_count++;
                    if (exp_pkt.t != '0) begin
                        pending_free.push_back(exp_pkt.t_old);
                    end
                end
            end
            if (n_valid > last_space) begin
                fail_count++;
                $display("%0d packets renamed at %0t with ROB or RS space for %0d",
                         n_valid, $time, last_space);
            end
            if ((n_valid != 0) && (avail < `N)) begin
                fail_count++;
                $display("dispatch at %0t with only %0d free registers", $time, avail);
            end
            // retire slots driven now land at the next edge
            last_push = 0;
            for (int i = 0; i < `N; i++) begin
                if (retire_regs[i].valid) begin
                    model_fl.push_back(retire_regs[i].reg_idx);
                    last_push++;
                end
            end
            // space offered to the group dispatching now
            last_space = (rob_open < rs_open) ? rob_open : rs_open;
        end
    end

    // hang guard
    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run not finished after %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed         = 8;
        in_insts     = '0;
        num_input    = '0;
        rob_open     = rename_pkg::count_t'(`IB_SZ);
        rs_open      = rename_pkg::count_t'(`IB_SZ);
        retire_regs  = '0;
        err_count    = 0;
        fail_count   = 0;
        out_count    = 0;
        acc_count    = 0;
        cycles       = 0;
        last_push    = 0;
        last_space   = `IB_SZ;
        rob_knob     = `IB_SZ;
        rs_knob      = `IB_SZ;
        retire_on    = 1'b1;
        stall_expect = 1'b0;
        // identity map, upper half free in order
        for (int a = 0; a < `ARCH_REG_SZ; a++) begin
            model_map[a] = rename_pkg::phys_reg_idx'(a);
        end
        for (int p = `ARCH_REG_SZ; p < `PHYS_REG_SZ; p++) begin
            model_fl.push_back(rename_pkg::phys_reg_idx'(p));
        end

        @(negedge reset);
        compare_count("ib_open", ib_open, rename_pkg::count_t'(`IB_SZ));
        for (int i = 0; i < `N; i++) begin
            if (renamed_insts[i].valid) begin
                fail_count++;
                $display("renamed_insts[%0d] valid right after reset", i);
            end
        end

        // first group, identity sources and dests 32..34
        stage_q.push_back(make_inst(1, 2, 1));
        stage_q.push_back(make_inst(3, 4, 2));
        stage_q.push_back(make_inst(5, 6, 3));
        drain();

        // read after write and write after write inside one group
        stage_q.push_back(make_inst(1, 2, 5));
        stage_q.push_back(make_inst(5, 5, 6));
        stage_q.push_back(make_inst(6, 5, 5));
        drain();

        // no dest, then the next allocator, then a bypassed read
        stage_q.push_back(make_inst(5, 6, 0));
        stage_q.push_back(make_inst(1, 2, 7));
        stage_q.push_back(make_inst(7, 0, 0));
        drain();

        // no ROB space, then no RS space
        for (int round = 0; round < 2; round++) begin
            stall_expect = 1'b1;
            rob_knob     = (round == 0) ? 0 : `IB_SZ;
            rs_knob      = (round == 0) ? `IB_SZ : 0;
            repeat (12) stage_q.push_back(random_inst(1'b0));
            repeat (12) step();
            compare_count("ib_open", ib_open, '0);
            stall_expect = 1'b0;
            rob_knob     = `IB_SZ;
            rs_knob      = `IB_SZ;
            drain();
        end

        // free list runs short without retirement
        retire_on = 1'b0;
        repeat (42) stage_q.push_back(random_inst(1'b1));
        repeat (30) step();
        if (model_fl.size() >= `N) begin
            fail_count++;
            $display("free list still holds %0d registers, dispatch never starved",
                     model_fl.size());
        end
        stall_expect = 1'b1;
        repeat (10) step();
        compare_count("ib_open", ib_open, '0);
        stall_expect = 1'b0;
        // returned registers come back in push order
        retire_on = 1'b1;
        drain();

        // mixed group sizes, random space and retirement
        rob_knob = -1;
        rs_knob  = -1;
        for (int g = 0; g < RAND_GROUPS; g++) begin
            repeat (1 + $unsigned($random(seed)) % `N) stage_q.push_back(random_inst(1'b0));
            repeat (1 + ($random(seed) & 1)) step();
        end
        rob_knob = `IB_SZ;
        rs_knob  = `IB_SZ;
        drain();
        if (out_count != acc_count) begin
            err_count++;
            $display("ERR %0t out_count got %0d exp %0d", $time, out_count, acc_count);
        end

        $display("summary: %0d packets, %0d value errors, %0d other errors",
                 out_count, err_count, fail_count);
        if ((err_count == 0) && (fail_count == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/inst_buffer.sv
verilog/dispatch_ctrl.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rename_core.sv
test/tb_clock_gen.sv
test/rename_core_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rename_pkg.sv
      - verilog/inst_buffer.sv
      - verilog/dispatch_ctrl.sv
      - verilog/free_list.sv
      - verilog/map_table.sv
      - verilog/rename_core.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock_gen.sv
      - test/rename_core_tb.sv
